//--- Makefile
# Verilator build and run for the compute-SRAM subsystem

VERILATOR ?= verilator
TOP       ?= tb_c3sram
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failures found" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- c3sram_arbiter.sv
/*
 * Two-port front end for the macro
 * Four-phase req/ack per port, round-robin grant, start pulse to the
 * controller and per-port read data registers
 */

`timescale 1ns/1ps
`default_nettype none

module c3sram_arbiter (
    input  wire logic                                                  clk,
    input  wire logic                                                  nrst,

    // Client ports
    input  wire logic [c3sram_pkg::NUM_PORTS-1:0]                      req_i,
    input  wire logic [c3sram_pkg::NUM_PORTS-1:0]                      we_i,
    input  wire logic [c3sram_pkg::NUM_PORTS-1:0][c3sram_pkg::ADDR_W-1:0]   addr_i,
    input  wire logic [c3sram_pkg::NUM_PORTS-1:0][c3sram_pkg::NUM_COLS-1:0] wdata_i,
    output logic      [c3sram_pkg::NUM_PORTS-1:0]                      ack_o,
    output logic      [c3sram_pkg::NUM_PORTS-1:0][c3sram_pkg::NUM_COLS-1:0] rdata_o,

    // Controller and macro side
    output logic                                                       write_o,
    output logic                                                       read_o,
    output logic      [c3sram_pkg::ADDR_W-1:0]                         addr_o,
    output logic      [c3sram_pkg::NUM_COLS-1:0]                       wdata_o,
    input  wire logic                                                  ready_i,
    input  wire logic                                                  done_i,
    input  wire logic [c3sram_pkg::NUM_COLS-1:0]                       sense_data_i
);

    import c3sram_pkg::*;

    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

    typedef enum logic [1:0] {
        A_IDLE,
        A_ISSUE,
        A_BUSY,
        A_ACK
    } arb_state_t;

    arb_state_t               state_q;
    port_idx_t                last_q;
    port_idx_t                port_q;
    logic                     we_q;
    logic [ADDR_W-1:0]        addr_q;
    logic [NUM_COLS-1:0]      wdata_q;

    logic [NUM_PORTS-1:0]     eligible;
    logic                     grant_valid;
    port_idx_t                grant_idx;

    // A port still holding ack waits for its req to fall first
    assign eligible = req_i & ~ack_o;

    // Round-robin search starting after the last served port
    always_comb begin
        port_idx_t cand;
        cand        = last_q;
        grant_valid = 1'b0;
        grant_idx   = last_q;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = port_idx_t'((int'(last_q) + i) % NUM_PORTS);
            if (!grant_valid && eligible[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    // Grant sequencing and per-port ack
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= A_IDLE;
            last_q  <= '0;
            port_q  <= '0;
            we_q    <= 1'b0;
            ack_o   <= '0;
            rdata_o <= '0;
        end else begin
            // Ack drops once the client has released req
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (ack_o[p] && !req_i[p]) begin
                    ack_o[p] <= 1'b0;
                end
            end
            case (state_q)
                A_IDLE: begin
                    if (grant_valid) begin
                        state_q <= A_ISSUE;
                        port_q  <= grant_idx;
                        last_q  <= grant_idx;
                        we_q    <= we_i[grant_idx];
                    end
                end
                A_ISSUE: begin
                    if (ready_i) begin
                        state_q <= A_BUSY;
                    end
                end
                A_BUSY: begin
                    if (done_i) begin
                        state_q <= A_ACK;
                    end
                end
                A_ACK: begin
                    // Sense latch is valid one edge after done
                    if (!we_q) begin
                        rdata_o[port_q] <= sense_data_i;
                    end
                    ack_o[port_q] <= 1'b1;
                    state_q       <= A_IDLE;
                end
                default: state_q <= A_IDLE;
            endcase
        end
    end

    // Operation payload, held for the whole operation
    always_ff @(posedge clk) begin
        if (state_q == A_IDLE && grant_valid) begin
            addr_q  <= addr_i[grant_idx];
            wdata_q <= wdata_i[grant_idx];
        end
    end

    assign write_o = (state_q == A_ISSUE) && ready_i && we_q;
    assign read_o  = (state_q == A_ISSUE) && ready_i && !we_q;
    assign addr_o  = addr_q;
    assign wdata_o = wdata_q;

    // The client may drop req as soon as it sees ack, so req is checked at the raising edge
    generate
        for (genvar g = 0; g < NUM_PORTS; g++) begin : g_ack_chk
            assert property (@(posedge clk) disable iff (!nrst)
                $rose(ack_o[g]) |-> $past(req_i[g]))
                else $error("ack raised on port %0d without req", g);
        end
    endgenerate

    // Only the granted port can see ack rise
    assert property (@(posedge clk) disable iff (!nrst)
        $onehot0(ack_o & ~$past(ack_o)))
        else $error("more than one ack rose in one cycle");

endmodule

`default_nettype wire

//--- c3sram_macro.sv
/*
 * Behavioral bitcell array
 * Row storage, write drivers and the sense-amplifier latch
 */

`timescale 1ns/1ps
`default_nettype none

module c3sram_macro (
    input  wire logic                             clk,
    input  wire logic                             nrst,
    input  wire logic                             csel_i,
    input  wire logic                             saen_i,
    input  wire logic                             w2b_i,
    input  wire logic                             nprecharge_i,
    input  wire logic [c3sram_pkg::NUM_ROWS-1:0]  wl_i,
    input  wire logic [c3sram_pkg::NUM_COLS-1:0]  wdata_i,
    output logic      [c3sram_pkg::NUM_COLS-1:0]  sense_data_o
);

    import c3sram_pkg::*;

    logic [NUM_COLS-1:0] mem [NUM_ROWS];
    logic [ADDR_W-1:0]   row_sel;
    logic                wl_active;
    logic [NUM_COLS-1:0] bitline;

    // Wordlines are one-hot, decode to a row index
    always_comb begin
        row_sel = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (wl_i[r]) begin
                row_sel = ADDR_W'(r);
            end
        end
    end

    assign wl_active = |wl_i;

    // Bitlines sit precharged high unless a row is connected
    assign bitline = (wl_active && nprecharge_i) ? mem[row_sel] : '1;

    // Write drivers overpower the selected cells
    always_ff @(posedge clk) begin
        if (w2b_i && nprecharge_i && wl_active) begin
            mem[row_sel] <= wdata_i;
        end
    end

    // Sense amplifier latch
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sense_data_o <= '0;
        end else if (saen_i && csel_i) begin
            sense_data_o <= bitline;
        end
    end

    // Sensing an unselected bitline would latch the precharge level
    assert property (@(posedge clk) disable iff (!nrst)
        $rose(saen_i) |-> wl_active)
        else $error("sense enable rose with no wordline active");

endmodule

`default_nettype wire

//--- c3sram_pkg.sv
/*
 * Shared definitions for the compute-SRAM subsystem
 * Array geometry, port count and the controller strobe waveform tables
 */

`default_nettype none

package c3sram_pkg;

    // Array geometry
    localparam int NUM_ROWS  = 8;
    localparam int NUM_COLS  = 8;
    localparam int ADDR_W    = 3;

    // Client ports sharing the macro
    localparam int NUM_PORTS = 2;

    // Write waveforms, bit n applies while the phase counter equals n
    localparam logic [3:0] WR_W2B_WAVE  = 4'b1111;
    localparam logic [3:0] WR_NPRE_WAVE = 4'b1111;
    localparam logic [3:0] WR_WL_WAVE   = 4'b0110;

    // Read waveforms
    // Sense enable sits in phase 1 with the wordline still up
    localparam logic [3:0] RD_SAEN_WAVE = 4'b0010;
    localparam logic [3:0] RD_CSEL_WAVE = 4'b1010;
    localparam logic [3:0] RD_NPRE_WAVE = 4'b1110;
    localparam logic [3:0] RD_WL_WAVE   = 4'b0110;

    // Phase counter counts down from here to 0
    localparam logic [1:0] PHASE_START  = 2'd3;

endpackage

`default_nettype wire

//--- c3sram_top.sv
/*
 * Top level of the compute-SRAM subsystem
 * Arbiter, row-access controller and bitcell macro
 */

`timescale 1ns/1ps
`default_nettype none

module c3sram_top (
    input  wire logic                                                  clk,
    input  wire logic                                                  nrst,
    input  wire logic [c3sram_pkg::NUM_PORTS-1:0]                      req_i,
    input  wire logic [c3sram_pkg::NUM_PORTS-1:0]                      we_i,
    input  wire logic [c3sram_pkg::NUM_PORTS-1:0][c3sram_pkg::ADDR_W-1:0]   addr_i,
    input  wire logic [c3sram_pkg::NUM_PORTS-1:0][c3sram_pkg::NUM_COLS-1:0] wdata_i,
    output logic      [c3sram_pkg::NUM_PORTS-1:0]                      ack_o,
    output logic      [c3sram_pkg::NUM_PORTS-1:0][c3sram_pkg::NUM_COLS-1:0] rdata_o
);

    import c3sram_pkg::*;

    // Arbiter to controller
    logic                 write;
    logic                 read;
    logic [ADDR_W-1:0]    row_addr;
    logic                 ready;
    logic                 done;

    // Macro data and strobes
    logic [NUM_COLS-1:0]  wdata;
    logic [NUM_COLS-1:0]  sense_data;
    logic                 csel;
    logic                 saen;
    logic                 w2b;
    logic                 nprecharge;
    logic [NUM_ROWS-1:0]  wl;

    c3sram_arbiter u_arbiter (
        .clk          (clk),
        .nrst         (nrst),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .ack_o        (ack_o),
        .rdata_o      (rdata_o),
        .write_o      (write),
        .read_o       (read),
        .addr_o       (row_addr),
        .wdata_o      (wdata),
        .ready_i      (ready),
        .done_i       (done),
        .sense_data_i (sense_data)
    );

    wr_controller u_ctrl (
        .clk                 (clk),
        .nrst                (nrst),
        .write_i             (write),
        .read_i              (read),
        .addr_i              (row_addr),
        .done_o              (done),
        .ready_o             (ready),
        .c3sram_csel_o       (csel),
        .c3sram_saen_o       (saen),
        .c3sram_w2b_o        (w2b),
        .c3sram_nprecharge_o (nprecharge),
        .c3sram_wl_o         (wl)
    );

    c3sram_macro u_macro (
        .clk          (clk),
        .nrst         (nrst),
        .csel_i       (csel),
        .saen_i       (saen),
        .w2b_i        (w2b),
        .nprecharge_i (nprecharge),
        .wl_i         (wl),
        .wdata_i      (wdata),
        .sense_data_o (sense_data)
    );

endmodule

`default_nettype wire

//--- list.f
c3sram_pkg.sv
wr_controller.sv
c3sram_arbiter.sv
c3sram_macro.sv
c3sram_top.sv
tb_clkgen.sv
tb_c3sram.sv

//--- tb_c3sram.sv
/*
 * Directed testbench for the compute-SRAM subsystem
 * Reference memory, four-phase client transfers, cycle timeout and summary
 */

`timescale 1ns/1ps
`default_nettype none

module tb_c3sram;

    import c3sram_pkg::*;

    localparam int          PORT_W         = $clog2(NUM_PORTS);
    localparam int          RANDOM_OPS     = 60;
    localparam logic [31:0] SEED           = 32'hc80ec8b1;
    // About 110 transfers of roughly 12 cycles each, with a wide margin for waiting
    localparam int          TIMEOUT_CYCLES = 4000;

    logic                               clk;
    logic                               nrst;
    logic [NUM_PORTS-1:0]               req;
    logic [NUM_PORTS-1:0]               we;
    logic [NUM_PORTS-1:0][ADDR_W-1:0]   addr;
    logic [NUM_PORTS-1:0][NUM_COLS-1:0] wdata;
    logic [NUM_PORTS-1:0]               ack;
    logic [NUM_PORTS-1:0][NUM_COLS-1:0] rdata;

    logic [NUM_COLS-1:0] ref_mem [NUM_ROWS];
    int                  errors = 0;
    int                  checks = 0;
    int                  cycles = 0;

    tb_clkgen u_clkgen (
        .clk  (clk),
        .nrst (nrst)
    );

    c3sram_top DUT (
        .clk     (clk),
        .nrst    (nrst),
        .req_i   (req),
        .we_i    (we),
        .addr_i  (addr),
        .wdata_i (wdata),
        .ack_o   (ack),
        .rdata_o (rdata)
    );

    always @(posedge clk) begin
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: a handshake did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    // Odd multiplier keeps every row's pattern distinct
    function automatic logic [NUM_COLS-1:0] row_pattern(input logic [ADDR_W-1:0] row,
                                                         input logic [NUM_COLS-1:0] salt);
        logic [31:0] mixed;
        mixed = (32'(row) * 32'd37) ^ 32'h0000_005a;
        return mixed[NUM_COLS-1:0] ^ salt;
    endfunction

    // One four-phase transfer on port p, read data checked against the reference
    task automatic run_transfer(input logic [PORT_W-1:0] p, input logic wr,
                                input logic [ADDR_W-1:0] row,
                                input logic [NUM_COLS-1:0] data, input string name);
        logic [NUM_COLS-1:0] expected;
        expected = ref_mem[row];
        @(posedge clk);
        #1;
        we[p]    = wr;
        addr[p]  = row;
        wdata[p] = data;
        req[p]   = 1'b1;
        while (ack[p] !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        if (wr) begin
            ref_mem[row] = data;
        end else begin
            checks++;
            if (rdata[p] !== expected) begin
                errors++;
                $display("Mismatch in %s: port %0d row %0d expected 0x%h actual 0x%h",
                         name, p, row, expected, rdata[p]);
            end
        end
        req[p] = 1'b0;
        while (ack[p] !== 1'b0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_reset();
        @(posedge clk);
        #1;
        checks += 2;
        if (ack !== '0) begin
            errors++;
            $display("Mismatch in reset: ack expected %b actual %b", 2'b00, ack);
        end
        if (rdata !== '0) begin
            errors++;
            $display("Mismatch in reset: rdata expected 0x%h actual 0x%h", 16'h0000, rdata);
        end
    endtask

    task automatic write_read_rows();
        logic [ADDR_W-1:0] row;
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = ADDR_W'(r);
            run_transfer(1'b0, 1'b1, row, row_pattern(row, '0), "write_read_rows");
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = ADDR_W'(r);
            run_transfer(1'b0, 1'b0, row, '0, "write_read_rows");
        end
    endtask

    // Port 1 fills the array and port 0 reads it back
    task automatic cross_port_sharing();
        logic [ADDR_W-1:0] row;
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = ADDR_W'(r);
            run_transfer(1'b1, 1'b1, row, row_pattern(row, 8'ha5), "cross_port");
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = ADDR_W'(r);
            run_transfer(1'b0, 1'b0, row, '0, "cross_port");
        end
    endtask

    task automatic contention_pairs();
        logic [ADDR_W-1:0] row_a;
        logic [ADDR_W-1:0] row_b;
        for (int k = 0; k < NUM_ROWS / 2; k++) begin
            row_a = ADDR_W'(k);
            row_b = ADDR_W'(k + NUM_ROWS / 2);
            fork
                run_transfer(1'b0, 1'b1, row_a, row_pattern(row_a, 8'h3c), "contention");
                run_transfer(1'b1, 1'b1, row_b, row_pattern(row_b, 8'hc3), "contention");
            join
            fork
                run_transfer(1'b0, 1'b0, row_b, '0, "contention");
                run_transfer(1'b1, 1'b0, row_a, '0, "contention");
            join
        end
    endtask

    // Same-row pairs with a write run back to back, all others overlap
    task automatic random_traffic();
        int                  ops;
        int                  lag;
        logic [PORT_W-1:0]   p;
        logic                wr0;
        logic                wr1;
        logic [ADDR_W-1:0]   row0;
        logic [ADDR_W-1:0]   row1;
        logic [NUM_COLS-1:0] data0;
        logic [NUM_COLS-1:0] data1;
        ops = 0;
        while (ops < RANDOM_OPS) begin
            wr0   = 1'($urandom_range(1, 0));
            wr1   = 1'($urandom_range(1, 0));
            row0  = ADDR_W'($urandom_range(NUM_ROWS - 1, 0));
            row1  = ADDR_W'($urandom_range(NUM_ROWS - 1, 0));
            data0 = NUM_COLS'($urandom);
            data1 = NUM_COLS'($urandom);
            if (ops + 2 <= RANDOM_OPS && $urandom_range(3, 0) != 0) begin
                if (row0 == row1 && (wr0 || wr1)) begin
                    run_transfer(1'b0, wr0, row0, data0, "random");
                    run_transfer(1'b1, wr1, row1, data1, "random");
                end else begin
                    lag = $urandom_range(2, 0);
                    fork
                        run_transfer(1'b0, wr0, row0, data0, "random");
                        begin
                            repeat (lag) @(posedge clk);
                            run_transfer(1'b1, wr1, row1, data1, "random");
                        end
                    join
                end
                ops += 2;
            end else begin
                p = PORT_W'($urandom_range(NUM_PORTS - 1, 0));
                run_transfer(p, wr0, row0, data0, "random");
                ops += 1;
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        req   = '0;
        we    = '0;
        addr  = '0;
        wdata = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            ref_mem[r] = '0;
        end
        wait (nrst === 1'b1);
        check_reset();
        write_read_rows();
        cross_port_sharing();
        contention_pairs();
        random_traffic();
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
/*
 * Testbench clock and reset generator
 * 10 ns clock, active-low reset held for the first cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release just after an edge so the first sampled cycle is clean
    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nrst = 1'b1;
    end

endmodule

`default_nettype wire

//--- wr_controller.sv
/*
 * Row-access controller for the bitcell macro
 * Idle/writing/reading FSM with a down-counting phase counter that
 * plays the package waveform tables onto the macro strobes
 */

`timescale 1ns/1ps
`default_nettype none

module wr_controller (
    input  wire logic                             clk,
    input  wire logic                             nrst,

    // One-cycle start pulses, only accepted while ready_o is high
    input  wire logic                             write_i,
    input  wire logic                             read_i,
    input  wire logic [c3sram_pkg::ADDR_W-1:0]    addr_i,

    output logic                                  done_o,
    output logic                                  ready_o,

    // Macro strobes
    output logic                                  c3sram_csel_o,
    output logic                                  c3sram_saen_o,
    output logic                                  c3sram_w2b_o,
    output logic                                  c3sram_nprecharge_o,
    output logic [c3sram_pkg::NUM_ROWS-1:0]       c3sram_wl_o
);

    import c3sram_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITING,
        S_READING
    } ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic [1:0]  phase_q;

    // State register
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (write_i && !read_i) begin
                    state_d = S_WRITING;
                end else if (read_i && !write_i) begin
                    state_d = S_READING;
                end
            end
            S_WRITING, S_READING: begin
                // Last phase of either operation
                if (phase_q == 2'd0) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    // Phase counter, held at the start value while idle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            phase_q <= PHASE_START;
        end else if (state_q == S_IDLE || phase_q == 2'd0) begin
            phase_q <= PHASE_START;
        end else begin
            phase_q <= phase_q - 2'd1;
        end
    end

    // Strobes looked up from the waveform tables
    always_comb begin
        c3sram_csel_o       = 1'b0;
        c3sram_saen_o       = 1'b0;
        c3sram_w2b_o        = 1'b0;
        c3sram_nprecharge_o = 1'b0;
        c3sram_wl_o         = '0;
        case (state_q)
            S_WRITING: begin
                c3sram_w2b_o          = WR_W2B_WAVE[phase_q];
                c3sram_nprecharge_o   = WR_NPRE_WAVE[phase_q];
                c3sram_wl_o[addr_i]   = WR_WL_WAVE[phase_q];
            end
            S_READING: begin
                c3sram_csel_o         = RD_CSEL_WAVE[phase_q];
                c3sram_saen_o         = RD_SAEN_WAVE[phase_q];
                c3sram_nprecharge_o   = RD_NPRE_WAVE[phase_q];
                c3sram_wl_o[addr_i]   = RD_WL_WAVE[phase_q];
            end
            default: begin
                c3sram_wl_o = '0;
            end
        endcase
    end

    assign ready_o = (state_q == S_IDLE);

    // Reads finish one phase early, sense data is latched at the end of phase 1
    always_comb begin
        case (state_q)
            S_WRITING: done_o = (phase_q == 2'd0);
            S_READING: done_o = (phase_q == 2'd1);
            default:   done_o = 1'b0;
        endcase
    end

    // Start pulses are mutually exclusive
    assert property (@(posedge clk) disable iff (!nrst)
        !(write_i && read_i))
        else $error("write and read start pulses high together");

    // At most one wordline is ever driven
    assert property (@(posedge clk) disable iff (!nrst)
        $onehot0(c3sram_wl_o))
        else $error("more than one wordline active");

endmodule

`default_nettype wire
